// ==== include/profiler_config.svh ====
// profiler configuration: widths and depths shared by the profiler blocks
`ifndef PROFILER_CONFIG_SVH
`define PROFILER_CONFIG_SVH

// function number width, eight functions
`define PROF_FUNC_W 3

// instruction address width
`define PROF_ADDR_W 16

// call stack address width, sixteen entries
`define PROF_STACK_AW 4

// per-function instruction counter width
`define PROF_COUNT_W 16

`endif

// ==== rtl/profiler_pkg.sv ====
// profiler package: opcode and run-state enums, function number, address and count types
`include "profiler_config.svh"

package profiler_pkg;

	// instruction class as seen on the retire trace
	typedef enum logic [1:0] {
		OP_OTHER = 2'd0, // ordinary instruction, counted
		OP_CALL  = 2'd1, // carries a target address
		OP_RET   = 2'd2
	} instr_op_e;

	// run progress, a second run needs a reset
	typedef enum logic [1:0] {
		RUN_IDLE   = 2'd0,
		RUN_ACTIVE = 2'd1,
		RUN_DONE   = 2'd2
	} run_state_e;

	typedef logic [`PROF_FUNC_W-1:0]  func_num_t;
	typedef logic [`PROF_ADDR_W-1:0]  instr_addr_t;
	typedef logic [`PROF_COUNT_W-1:0] count_t;

endpackage

// ==== rtl/call_decoder.sv ====
// call decoder: maps call targets to function numbers and registers one event per instruction
`timescale 1ns/1ps
`include "profiler_config.svh"

module call_decoder (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      tbl_we,
	input  profiler_pkg::func_num_t   tbl_index,
	input  profiler_pkg::instr_addr_t tbl_addr,
	input  logic                      instr_valid,
	input  profiler_pkg::instr_op_e   instr_op,
	input  profiler_pkg::instr_addr_t instr_target,
	output logic                      call_ev,
	output logic                      retn_ev,
	output logic                      cnt_ev,
	output profiler_pkg::func_num_t   func_num
);
	localparam int NUM_FUNC = 1 << `PROF_FUNC_W;

	profiler_pkg::instr_addr_t entry_addr [NUM_FUNC]; // function entry points
	logic [NUM_FUNC-1:0]       entry_vld;
	logic [NUM_FUNC-1:0]       hit_vec;
	logic                      hit;
	profiler_pkg::func_num_t   hit_num;
	logic                      is_call;
	logic                      is_ret;
	logic                      is_other;

	// software loads one entry address per function
	always_ff @(posedge clk) begin
		if (tbl_we)
			entry_addr[tbl_index] <= tbl_addr;
	end

	always_ff @(posedge clk) begin
		if (reset)
			entry_vld <= '0;
		else if (tbl_we)
			entry_vld[tbl_index] <= 1'b1;
	end

	// parallel compare of the call target against every loaded entry
	always_comb begin
		for (int i = 0; i < NUM_FUNC; i++)
			hit_vec[i] = entry_vld[i] && (entry_addr[i] == instr_target);
	end

	// lowest matching entry wins
	always_comb begin
		hit_num = '0;
		for (int i = NUM_FUNC - 1; i >= 0; i--) begin
			if (hit_vec[i])
				hit_num = profiler_pkg::func_num_t'(i);
		end
	end

	assign hit = |hit_vec;

	assign is_call  = instr_valid && (instr_op == profiler_pkg::OP_CALL);
	assign is_ret   = instr_valid && (instr_op == profiler_pkg::OP_RET);
	assign is_other = instr_valid && (instr_op == profiler_pkg::OP_OTHER);

	always_ff @(posedge clk) begin
		if (reset) begin
			call_ev  <= 1'b0;
			retn_ev  <= 1'b0;
			cnt_ev   <= 1'b0;
			func_num <= '0;
		end else begin
			call_ev  <= is_call & hit;
			retn_ev  <= is_ret;
			cnt_ev   <= is_other | (is_call & ~hit); // unlisted call counts for the caller
			func_num <= hit_num;
		end
	end

	// every valid instruction gives exactly one event, never two at once
	a_single_event: assert property (@(posedge clk) disable iff (reset)
		instr_valid |=> $onehot({call_ev, retn_ev, cnt_ev}));

endmodule

// ==== rtl/address_stack.sv ====
// address stack: call chain RAM, event alignment pipeline and run-state tracking
`timescale 1ns/1ps
`include "profiler_config.svh"

module address_stack (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     call_ev,
	input  logic                     retn_ev,
	input  logic                     cnt_ev,
	input  profiler_pkg::func_num_t  func_num,
	output logic                     call_cs,
	output logic                     retn_cs,
	output logic                     cnt_inc_cs,
	output profiler_pkg::func_num_t  top_func,
	output profiler_pkg::run_state_e run_state,
	output logic                     exe_done
);
	localparam int DEPTH = 1 << `PROF_STACK_AW;
	localparam logic [`PROF_STACK_AW-1:0] PTR_EMPTY = '1;
	// all ones marks empty, so the last slot stays unused
	localparam logic [`PROF_STACK_AW-1:0] PTR_FULL = PTR_EMPTY - 1'b1;

	logic                        call_r;
	logic                        retn_r;
	logic                        cnt_r;
	logic                        exe_end_r; // lines up with retn_cs
	logic                        stack_wren;
	profiler_pkg::func_num_t     stack_wr_data;
	logic [`PROF_STACK_AW-1:0]   stack_addr;
	logic [`PROF_STACK_AW-1:0]   rd_addr_q;
	profiler_pkg::func_num_t     stack_mem [DEPTH];

	assign exe_done = (run_state == profiler_pkg::RUN_DONE);

	// two-stage delay so the strobes meet the stack read data
	always_ff @(posedge clk) begin
		if (reset) begin
			call_r     <= 1'b0;
			retn_r     <= 1'b0;
			cnt_r      <= 1'b0;
			call_cs    <= 1'b0;
			retn_cs    <= 1'b0;
			cnt_inc_cs <= 1'b0;
		end else begin
			call_r     <= call_ev;
			retn_r     <= retn_ev;
			cnt_r      <= cnt_ev;
			call_cs    <= call_r & ~(exe_end_r | exe_done);
			retn_cs    <= retn_r & ~(exe_end_r | exe_done);
			cnt_inc_cs <= cnt_r & (run_state == profiler_pkg::RUN_ACTIVE) & ~exe_end_r;
		end
	end

	// push on call, pop on return
	always_ff @(posedge clk) begin
		if (reset) begin
			stack_wren <= 1'b0;
			stack_addr <= PTR_EMPTY; // first push lands on address 0
		end else begin
			stack_wren <= call_ev;
			if (call_ev)
				stack_addr <= stack_addr + 1'b1;
			else if (retn_ev)
				stack_addr <= stack_addr - 1'b1;
		end
	end

	always_ff @(posedge clk)
		stack_wr_data <= func_num;

	// single-port RAM with registered read address
	always_ff @(posedge clk) begin
		if (stack_wren)
			stack_mem[stack_addr] <= stack_wr_data;
		rd_addr_q <= stack_addr;
	end

	assign top_func = stack_mem[rd_addr_q]; // innermost active function

	always_ff @(posedge clk) begin
		if (reset) begin
			run_state <= profiler_pkg::RUN_IDLE;
			exe_end_r <= 1'b0;
		end else begin
			// outermost return leaves the pointer back at all ones
			exe_end_r <= (run_state == profiler_pkg::RUN_ACTIVE) && retn_r &&
				(stack_addr == PTR_EMPTY);
			case (run_state)
				profiler_pkg::RUN_IDLE:   if (call_r) run_state <= profiler_pkg::RUN_ACTIVE;
				profiler_pkg::RUN_ACTIVE: if (exe_end_r) run_state <= profiler_pkg::RUN_DONE;
				profiler_pkg::RUN_DONE:   run_state <= profiler_pkg::RUN_DONE; // held until reset
				default:                  run_state <= profiler_pkg::RUN_IDLE;
			endcase
		end
	end

	// call chain deeper than the stack would wrap onto the empty marker
	a_no_push_full: assert property (@(posedge clk) disable iff (reset || exe_done)
		call_ev |-> (stack_addr != PTR_FULL));

	a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
		(retn_ev && run_state == profiler_pkg::RUN_ACTIVE) |-> (stack_addr != PTR_EMPTY));

endmodule

// ==== rtl/counter_storage.sv ====
// counter storage: one saturating instruction counter per function with registered read-back
`timescale 1ns/1ps
`include "profiler_config.svh"

module counter_storage (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    cnt_inc_cs,
	input  profiler_pkg::func_num_t top_func,
	input  profiler_pkg::func_num_t rd_index,
	output profiler_pkg::count_t    rd_count
);
	localparam int NUM_FUNC = 1 << `PROF_FUNC_W;
	localparam profiler_pkg::count_t CNT_MAX = '1;

	profiler_pkg::count_t cnt [NUM_FUNC];
	logic [NUM_FUNC-1:0]  inc_sel;

	// one-hot select of the counter to bump
	always_comb begin
		for (int i = 0; i < NUM_FUNC; i++)
			inc_sel[i] = cnt_inc_cs && (top_func == profiler_pkg::func_num_t'(i));
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_FUNC; i++)
				cnt[i] <= '0;
		end else begin
			for (int i = 0; i < NUM_FUNC; i++) begin
				if (inc_sel[i] && (cnt[i] != CNT_MAX)) // sticks at max
					cnt[i] <= cnt[i] + 1'b1;
			end
		end
	end

	// read-back, one cycle after rd_index
	always_ff @(posedge clk) begin
		if (reset)
			rd_count <= '0;
		else
			rd_count <= cnt[rd_index];
	end

	// stack read data must be settled whenever a count lands
	a_top_func_known: assert property (@(posedge clk) disable iff (reset)
		cnt_inc_cs |-> !$isunknown(top_func));

endmodule

// ==== rtl/func_profiler.sv ====
// function profiler top: decoder, call stack and per-function counters
`timescale 1ns/1ps

module func_profiler (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      tbl_we,
	input  profiler_pkg::func_num_t   tbl_index,
	input  profiler_pkg::instr_addr_t tbl_addr,
	input  logic                      instr_valid,
	input  profiler_pkg::instr_op_e   instr_op,
	input  profiler_pkg::instr_addr_t instr_target,
	output profiler_pkg::run_state_e  run_state,
	output logic                      exe_done,
	input  profiler_pkg::func_num_t   rd_index,
	output profiler_pkg::count_t      rd_count
);
	logic                    call_ev;
	logic                    retn_ev;
	logic                    cnt_ev;
	profiler_pkg::func_num_t func_num;
	logic                    cnt_inc_cs;
	profiler_pkg::func_num_t top_func;

	call_decoder u_decoder (
		.clk          (clk),
		.reset        (reset),
		.tbl_we       (tbl_we),
		.tbl_index    (tbl_index),
		.tbl_addr     (tbl_addr),
		.instr_valid  (instr_valid),
		.instr_op     (instr_op),
		.instr_target (instr_target),
		.call_ev      (call_ev),
		.retn_ev      (retn_ev),
		.cnt_ev       (cnt_ev),
		.func_num     (func_num)
	);

	address_stack u_stack (
		.clk        (clk),
		.reset      (reset),
		.call_ev    (call_ev),
		.retn_ev    (retn_ev),
		.cnt_ev     (cnt_ev),
		.func_num   (func_num),
		.call_cs    (),          // counters only need the count strobe
		.retn_cs    (),
		.cnt_inc_cs (cnt_inc_cs),
		.top_func   (top_func),
		.run_state  (run_state),
		.exe_done   (exe_done)
	);

	counter_storage u_counters (
		.clk        (clk),
		.reset      (reset),
		.cnt_inc_cs (cnt_inc_cs),
		.top_func   (top_func),
		.rd_index   (rd_index),
		.rd_count   (rd_count)
	);

endmodule

// ==== verification/func_profiler_tb.sv ====
// function profiler testbench: table-driven retire trace checked against a reference call stack
`timescale 1ns/1ps
`include "profiler_config.svh"

module func_profiler_tb;
	localparam int NUM_FUNC     = 1 << `PROF_FUNC_W;
	localparam int DONE_TIMEOUT = 40; // cycles
	localparam profiler_pkg::instr_op_e   OTHER    = profiler_pkg::OP_OTHER;
	localparam profiler_pkg::instr_op_e   CALL     = profiler_pkg::OP_CALL;
	localparam profiler_pkg::instr_op_e   RET      = profiler_pkg::OP_RET;
	localparam profiler_pkg::instr_addr_t UNLISTED = 16'h7ff0; // in no table entry

	logic                      clk = 1'b0;
	logic                      reset;
	logic                      tbl_we;
	profiler_pkg::func_num_t   tbl_index;
	profiler_pkg::instr_addr_t tbl_addr;
	logic                      instr_valid;
	profiler_pkg::instr_op_e   instr_op;
	profiler_pkg::instr_addr_t instr_target;
	profiler_pkg::run_state_e  run_state;
	logic                      exe_done;
	profiler_pkg::func_num_t   rd_index;
	profiler_pkg::count_t      rd_count;

	// trace rows, and per phase the last row, expected state and back-to-back flag
	profiler_pkg::instr_op_e   row_op [$];
	profiler_pkg::instr_addr_t row_tgt [$];
	int                        phase_end [$];
	profiler_pkg::run_state_e  phase_state [$];
	bit                        phase_burst [$];

	int                   ref_stack [$]; // reference call chain, innermost last
	profiler_pkg::count_t ref_cnt [NUM_FUNC];
	bit                   ref_done;

	func_profiler func_profiler_i (.*);

	always #4 clk = ~clk;

	function automatic profiler_pkg::instr_addr_t entry_of(input int fn);
		return profiler_pkg::instr_addr_t'(32'h4000 + fn * 32'h230);
	endfunction

	task automatic add_rows(input profiler_pkg::instr_op_e op,
		input profiler_pkg::instr_addr_t tgt, input int n);
		for (int i = 0; i < n; i++) begin
			row_op.push_back(op);
			row_tgt.push_back(tgt);
		end
	endtask

	task automatic end_phase(input profiler_pkg::run_state_e st, input bit burst);
		phase_end.push_back(row_op.size());
		phase_state.push_back(st);
		phase_burst.push_back(burst);
	endtask

	// counts go to the innermost function, between the first call and the outermost return
	task automatic ref_step(input profiler_pkg::instr_op_e op, input profiler_pkg::instr_addr_t tgt);
		int fn;
		fn = -1;
		for (int i = 0; i < NUM_FUNC; i++) begin
			if (op == CALL && tgt == entry_of(i))
				fn = i;
		end
		if (!ref_done) begin
			if (fn >= 0)
				ref_stack.push_back(fn);
			else if (op == RET && ref_stack.size() > 0) begin
				void'(ref_stack.pop_back());
				ref_done = (ref_stack.size() == 0);
			end else if (ref_stack.size() > 0)
				ref_cnt[ref_stack[$]] = ref_cnt[ref_stack[$]] + 1'b1; // unlisted call too
		end
	endtask

	task automatic stop_run(input string why);
		$display("Test FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check_count(input int idx, input profiler_pkg::count_t got,
		input profiler_pkg::count_t exp);
		if (got !== exp) begin
			$display("Error at %0t: rd_count[%0d] = %0d, expected %0d", $time, idx, got, exp);
			stop_run("counter read-back mismatch");
		end
	endtask

	task automatic check_state(input profiler_pkg::run_state_e got,
		input profiler_pkg::run_state_e exp);
		if (got !== exp) begin
			$display("Error at %0t: run_state = %s, expected %s", $time, got.name(), exp.name());
			stop_run("run state mismatch");
		end
	endtask

	task automatic check_done(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t: exe_done = %b, expected %b", $time, got, exp);
			stop_run("exe_done mismatch");
		end
	endtask

	task automatic wait_for_done();
		int cycles;
		cycles = 0;
		while (exe_done !== 1'b1 && cycles < DONE_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (exe_done !== 1'b1)
			stop_run("timeout: exe_done never rose after the outermost return");
	endtask

	// one trace row, then a short random idle gap unless the phase runs back to back
	task automatic drive_row(input int r, input bit burst);
		int gap;
		gap = burst ? 0 : int'(1 + $urandom % 3);
		@(posedge clk);
		instr_valid  <= 1'b1;
		instr_op     <= row_op[r];
		instr_target <= row_tgt[r];
		ref_step(row_op[r], row_tgt[r]);
		repeat (gap) begin
			@(posedge clk);
			instr_valid <= 1'b0;
		end
	endtask

	task automatic load_table();
		for (int i = 0; i < NUM_FUNC; i++) begin
			@(posedge clk);
			tbl_we    <= 1'b1;
			tbl_index <= profiler_pkg::func_num_t'(i);
			tbl_addr  <= entry_of(i);
		end
		@(posedge clk);
		tbl_we <= 1'b0;
	endtask

	// rd_count follows rd_index by one cycle
	task automatic read_back_counters();
		for (int i = 0; i < NUM_FUNC; i++) begin
			@(posedge clk);
			rd_index <= profiler_pkg::func_num_t'(i);
			@(posedge clk);
			@(negedge clk);
			check_count(i, rd_count, ref_cnt[i]);
		end
	endtask

	task automatic build_trace();
		end_phase(profiler_pkg::RUN_IDLE, 1'b0); // straight after reset
		// nothing counts before the first call
		add_rows(OTHER, 16'h0012, 2);
		add_rows(CALL, UNLISTED, 1);
		end_phase(profiler_pkg::RUN_IDLE, 1'b0);
		// main, then three nested levels, spaced
		add_rows(CALL, entry_of(0), 1);
		add_rows(OTHER, 16'h0000, 2);
		add_rows(CALL, entry_of(3), 1);
		add_rows(OTHER, 16'h0000, 3);
		add_rows(CALL, entry_of(5), 1);
		add_rows(OTHER, 16'h0000, 1);
		add_rows(CALL, entry_of(6), 1);
		add_rows(OTHER, 16'h0000, 2);
		add_rows(CALL, UNLISTED, 1); // one instruction for func 6
		add_rows(RET, 16'h0000, 1);
		add_rows(OTHER, 16'h0000, 2);
		end_phase(profiler_pkg::RUN_ACTIVE, 1'b0);
		// consecutive cycles down to the outermost return
		add_rows(CALL, entry_of(1), 1);
		add_rows(OTHER, 16'h0000, 2);
		add_rows(CALL, entry_of(4), 1);
		add_rows(OTHER, 16'h0000, 1);
		add_rows(RET, 16'h0000, 2);
		add_rows(OTHER, 16'h0000, 1);
		add_rows(RET, 16'h0000, 2);
		add_rows(OTHER, 16'h0000, 2);
		add_rows(RET, 16'h0000, 1);
		end_phase(profiler_pkg::RUN_DONE, 1'b1);
		// trace after the run is ignored
		add_rows(OTHER, 16'h0000, 1);
		add_rows(CALL, entry_of(2), 1);
		add_rows(OTHER, 16'h0000, 2);
		add_rows(RET, 16'h0000, 2);
		end_phase(profiler_pkg::RUN_DONE, 1'b0);
	endtask

	initial begin
		void'($urandom(83));
		$timeformat(-9, 0, " ns", 0);
		reset        = 1'b1;
		tbl_we       = 1'b0;
		tbl_index    = '0;
		tbl_addr     = '0;
		instr_valid  = 1'b0;
		instr_op     = OTHER;
		instr_target = '0;
		rd_index     = '0;
		ref_done     = 1'b0;
		for (int i = 0; i < NUM_FUNC; i++)
			ref_cnt[i] = '0;
		build_trace();
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		load_table();
		for (int p = 0; p < phase_end.size(); p++) begin
			for (int r = (p == 0) ? 0 : phase_end[p-1]; r < phase_end[p]; r++)
				drive_row(r, phase_burst[p]);
			@(posedge clk);
			instr_valid <= 1'b0;
			repeat (4) @(posedge clk); // last count lands three cycles after its instruction
			if (phase_state[p] == profiler_pkg::RUN_DONE)
				wait_for_done();
			@(negedge clk);
			check_state(run_state, phase_state[p]);
			check_done(exe_done, phase_state[p] == profiler_pkg::RUN_DONE);
			read_back_counters();
		end
		$display("Test OK");
		$finish;
	end

endmodule

// ==== func_profiler.f ====
+incdir+include
rtl/profiler_pkg.sv
rtl/call_decoder.sv
rtl/address_stack.sv
rtl/counter_storage.sv
rtl/func_profiler.sv
verification/func_profiler_tb.sv

// ==== Makefile ====
TOP = func_profiler_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f func_profiler.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f func_profiler.f

clean:
	rm -rf obj_dir
